/* fog_loop_pkg.sv */
package fog_loop_pkg;

	// Photodetector sample from the ADC.
	typedef logic signed [13:0] adc_sample_t;

	// Phase code sent to the modulator DAC.
	typedef logic signed [15:0] phase_t;

	// Phase step, ladder and ramp accumulators.
	typedef logic signed [31:0] step_t;

	// Demodulated error over one eigen-period.
	typedef logic signed [23:0] err_t;

	// Eigen half-period in clocks.
	localparam int HALF_PERIOD = 8;

	// Counter widths for one half-period and one full period of samples.
	localparam int HP_CNT_W = $clog2(HALF_PERIOD);
	localparam int PERIOD_CNT_W = $clog2(2 * HALF_PERIOD);

	typedef logic [HP_CNT_W-1:0] hp_cnt_t;
	typedef logic [PERIOD_CNT_W-1:0] period_cnt_t;

	// Terminal counts.
	localparam hp_cnt_t HP_LAST = hp_cnt_t'(HALF_PERIOD - 1);
	localparam period_cnt_t PERIOD_LAST = period_cnt_t'(2 * HALF_PERIOD - 1);

	// Loop gain as a right shift of the period error.
	localparam int GAIN_SHIFT = 4;

	// Wrap bound used until the first V2pi value is registered.
	localparam int V2PI_RESET = 5000;

endpackage

/* fog_bias_mod.sv */
`timescale 1ns/1ps

module fog_bias_mod (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic [31:0]          i_v2pi,
	output logic                 o_trig,
	output logic                 o_sign,
	output fog_loop_pkg::phase_t o_mod
);

	fog_loop_pkg::hp_cnt_t cnt;
	logic [31:0]           quarter;
	fog_loop_pkg::phase_t  bias_amp;

	// Free-running half-period counter.
	// Trigger and sign flip land on the same cycle.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt    <= '0;
			o_trig <= 1'b0;
			o_sign <= 1'b0;
		end else begin
			if (cnt == fog_loop_pkg::HP_LAST) begin
				cnt    <= '0;
				o_trig <= 1'b1;
				o_sign <= ~o_sign;
			end else begin
				cnt    <= cnt + 1'b1;
				o_trig <= 1'b0;
			end
		end
	end

	// Quarter of V2pi gives the pi/2 dither.
	assign quarter  = i_v2pi >> 2;
	assign bias_amp = $signed(quarter[15:0]);

	// Positive half while sign is low.
	assign o_mod = o_sign ? -bias_amp : bias_amp;

endmodule

/* fog_demod.sv */
`timescale 1ns/1ps

module fog_demod (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  fog_loop_pkg::adc_sample_t i_adc,
	input  logic                      i_adc_valid,
	input  logic                      i_sign,
	output fog_loop_pkg::err_t        o_err,
	output logic                      o_err_valid
);

	fog_loop_pkg::period_cnt_t cnt;
	fog_loop_pkg::err_t        acc;
	fog_loop_pkg::err_t        adc_ext;
	fog_loop_pkg::err_t        term;
	fog_loop_pkg::err_t        sum;
	logic                      period_done;

	// Sign-multiply the sample by the bias half.
	assign adc_ext = fog_loop_pkg::err_t'(i_adc);
	assign term    = i_sign ? -adc_ext : adc_ext;
	assign sum     = acc + term;

	assign period_done = i_adc_valid && (cnt == fog_loop_pkg::PERIOD_LAST);

	// Sample count and accumulator over one eigen-period.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
			acc <= '0;
		end else if (i_adc_valid) begin
			if (period_done) begin
				cnt <= '0;
				acc <= '0;
			end else begin
				cnt <= cnt + 1'b1;
				acc <= sum;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= period_done;
		end
	end

	// Period result, qualified by o_err_valid.
	always_ff @(posedge i_clk) begin
		if (period_done) begin
			o_err <= sum;
		end
	end

endmodule

/* fog_loop_filter.sv */
`timescale 1ns/1ps

module fog_loop_filter (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_fb_on,
	input  fog_loop_pkg::err_t  i_err,
	input  logic                i_err_valid,
	input  logic [31:0]         i_v2pi,
	output fog_loop_pkg::step_t o_step,
	output logic                o_step_valid
);

	fog_loop_pkg::err_t  err_scaled;
	logic signed [32:0]  sum;
	logic signed [32:0]  lim_p;
	logic signed [32:0]  lim_n;
	fog_loop_pkg::step_t step_next;

	// Arithmetic shift sets the loop gain.
	assign err_scaled = i_err >>> fog_loop_pkg::GAIN_SHIFT;

	// One extra bit so the sum cannot overflow before the clamp.
	assign sum   = {o_step[31], o_step} + 33'(err_scaled);
	assign lim_p = $signed({1'b0, i_v2pi});
	assign lim_n = -lim_p;

	// Clamp keeps the step inside one wrap of the ramp.
	always_comb begin
		if (sum > lim_p) begin
			step_next = lim_p[31:0];
		end else if (sum < lim_n) begin
			step_next = lim_n[31:0];
		end else begin
			step_next = sum[31:0];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_step       <= '0;
			o_step_valid <= 1'b0;
		end else if (!i_fb_on) begin
			o_step       <= '0;
			o_step_valid <= 1'b0;
		end else begin
			o_step_valid <= i_err_valid;
			if (i_err_valid) begin
				o_step <= step_next;
			end
		end
	end

endmodule

/* phase_ramp_gen.sv */
`timescale 1ns/1ps

module phase_ramp_gen (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_trig,
	input  fog_loop_pkg::step_t  i_step,
	input  logic [31:0]          i_v2pi,
	input  logic                 i_fb_on,
	input  fog_loop_pkg::phase_t i_mod,
	output fog_loop_pkg::phase_t o_phase_ramp
);

	fog_loop_pkg::step_t ladder;
	fog_loop_pkg::step_t ramp;
	fog_loop_pkg::step_t v2pi_p;
	fog_loop_pkg::step_t v2pi_n;
	fog_loop_pkg::step_t v2pi_s;
	fog_loop_pkg::step_t two_v2pi;
	fog_loop_pkg::step_t mod_d;
	fog_loop_pkg::step_t ladder_sum;
	fog_loop_pkg::step_t ramp_sum;

	assign v2pi_s     = $signed(i_v2pi);
	assign two_v2pi   = v2pi_s + v2pi_s;
	assign ladder_sum = ladder + i_step;
	assign ramp_sum   = ladder + mod_d;

	// Bias aligned with the ladder it rides on.
	always_ff @(posedge i_clk) begin
		mod_d <= fog_loop_pkg::step_t'(i_mod);
	end

	// Wrap bounds.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			v2pi_p <= fog_loop_pkg::step_t'(fog_loop_pkg::V2PI_RESET);
			v2pi_n <= -fog_loop_pkg::step_t'(fog_loop_pkg::V2PI_RESET);
		end else begin
			v2pi_p <= v2pi_s;
			v2pi_n <= -v2pi_s;
		end
	end

	// Serrodyne staircase, one step per trigger.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ladder <= '0;
		end else if (!i_fb_on) begin
			ladder <= '0;
		end else if (i_trig && (i_step > 0)) begin
			if (ladder_sum >= v2pi_p) begin
				ladder <= ladder_sum - two_v2pi;
			end else begin
				ladder <= ladder_sum;
			end
		end else if (i_trig && (i_step < 0)) begin
			if (ladder_sum <= v2pi_n) begin
				ladder <= ladder_sum + two_v2pi;
			end else begin
				ladder <= ladder_sum;
			end
		end
	end

	// Ladder plus bias, wrapped in the direction of the step.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ramp <= '0;
		end else if (!i_fb_on) begin
			ramp <= '0;
		end else if (i_trig && (i_step > 0)) begin
			if (ramp_sum >= v2pi_p) begin
				ramp <= ramp_sum - two_v2pi;
			end else begin
				ramp <= ramp_sum;
			end
		end else if (i_trig && (i_step < 0)) begin
			if (ramp_sum <= v2pi_n) begin
				ramp <= ramp_sum + two_v2pi;
			end else begin
				ramp <= ramp_sum;
			end
		end
	end

	assign o_phase_ramp = ramp[15:0];

endmodule

/* fog_loop_top.sv */
`timescale 1ns/1ps

module fog_loop_top (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  fog_loop_pkg::adc_sample_t i_adc,
	input  logic                      i_adc_valid,
	input  logic [31:0]               i_v2pi,
	input  logic                      i_fb_on,
	output fog_loop_pkg::phase_t      o_dac,
	output fog_loop_pkg::step_t       o_rate,
	output logic                      o_rate_valid
);

	logic                 trig;
	logic                 bias_sign;
	fog_loop_pkg::phase_t mod;
	fog_loop_pkg::err_t   err;
	logic                 err_valid;

	fog_bias_mod u_bias_mod (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_v2pi  (i_v2pi),
		.o_trig  (trig),
		.o_sign  (bias_sign),
		.o_mod   (mod)
	);

	fog_demod u_demod (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_adc       (i_adc),
		.i_adc_valid (i_adc_valid),
		.i_sign      (bias_sign),
		.o_err       (err),
		.o_err_valid (err_valid)
	);

	// The accumulated step doubles as the rate reading.
	fog_loop_filter u_loop_filter (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_fb_on      (i_fb_on),
		.i_err        (err),
		.i_err_valid  (err_valid),
		.i_v2pi       (i_v2pi),
		.o_step       (o_rate),
		.o_step_valid (o_rate_valid)
	);

	phase_ramp_gen u_ramp (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_trig       (trig),
		.i_step       (o_rate),
		.i_v2pi       (i_v2pi),
		.i_fb_on      (i_fb_on),
		.i_mod        (mod),
		.o_phase_ramp (o_dac)
	);

endmodule

/* fog_loop_props.sv */
`timescale 1ns/1ps

module fog_loop_props (
	input logic                 i_clk,
	input logic                 i_rst_n,
	input logic                 i_fb_on,
	input logic [31:0]          i_v2pi,
	input logic                 i_trig,
	input logic                 i_err_valid,
	input logic                 i_rate_valid,
	input fog_loop_pkg::step_t  i_rate,
	input fog_loop_pkg::phase_t i_dac
);

	int fail_count = 0;
	int dac_lim;

	// The ramp may pass one wrap bound by the bias amplitude.
	assign dac_lim = int'(i_v2pi) + int'(i_v2pi >> 2);

	trig_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_trig |=> !i_trig)
		else begin
			fail_count++;
			$error("trig held longer than one cycle");
		end

	rate_follows_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_err_valid && i_fb_on) |=> i_rate_valid)
		else begin
			fail_count++;
			$error("o_rate_valid missing one cycle after err_valid");
		end

	dac_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_fb_on |-> (int'(i_dac) <= dac_lim) && (int'(i_dac) >= -dac_lim))
		else begin
			fail_count++;
			$error("o_dac outside the wrap range");
		end

	rate_zero_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_fb_on |=> (i_rate == 0))
		else begin
			fail_count++;
			$error("o_rate not zero with the loop off");
		end

endmodule

bind fog_loop_top fog_loop_props u_props (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_fb_on      (i_fb_on),
	.i_v2pi       (i_v2pi),
	.i_trig       (trig),
	.i_err_valid  (err_valid),
	.i_rate_valid (o_rate_valid),
	.i_rate       (o_rate),
	.i_dac        (o_dac)
);

/* fog_loop_tb.sv */
`timescale 1ns/1ps

module fog_loop_tb;

	typedef struct packed {
		logic        fb_on;
		logic [31:0] v2pi;
		int          mean;
		int          offset;
		int          noise;
		int          periods;
		int          sat;
	} row_t;

	logic                      clk;
	logic                      rst_n;
	fog_loop_pkg::adc_sample_t adc;
	logic                      adc_valid;
	logic [31:0]               v2pi;
	logic                      fb_on;
	fog_loop_pkg::phase_t      dac;
	fog_loop_pkg::step_t       rate;
	logic                      rate_valid;

	// fb_on, v2pi, ADC mean, bias offset d, noise amplitude, eigen-periods, saturation sign.
	// A v2pi change always goes through a row with the loop off.
	row_t rows [10] = '{
		'{1'b0, 32'd20000,  100,   300,  50,  4,  0},
		'{1'b1, 32'd20000,  200,   150,  40, 30,  0},
		'{1'b1, 32'd20000, -300,  1500, 100, 30,  1},
		'{1'b1, 32'd20000,   50, -2500,  80, 30, -1},
		'{1'b0, 32'd12000,    0,     0,  30,  3,  0},
		'{1'b1, 32'd12000,  400,   -90,  60, 25,  0},
		'{1'b1, 32'd12000, -100,  2000,   0, 12,  1},
		'{1'b0, 32'd26000,  150,     0,  20,  3,  0},
		'{1'b1, 32'd26000,  150, -2200,  70, 20, -1},
		'{1'b0, 32'd26000,    0,   500,  10,  3,  0}
	};

	logic [31:0] lfsr = 32'hf4b0_a816;
	int          n_pass = 0;
	int          n_fail = 0;
	int          row_fail;

	// Reference model state.
	int                  m_hcnt;
	logic                m_trig;
	logic                m_sign;
	int                  m_dcnt;
	fog_loop_pkg::err_t  m_acc;
	fog_loop_pkg::err_t  m_err;
	logic                m_err_valid;
	fog_loop_pkg::step_t m_step;
	logic                m_step_valid;
	fog_loop_pkg::step_t m_ladder;
	fog_loop_pkg::step_t m_ramp;
	fog_loop_pkg::step_t m_mod_d;
	fog_loop_pkg::step_t m_bound;

	fog_loop_top uut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_adc        (adc),
		.i_adc_valid  (adc_valid),
		.i_v2pi       (v2pi),
		.i_fb_on      (fb_on),
		.o_dac        (dac),
		.o_rate       (rate),
		.o_rate_valid (rate_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic fog_loop_pkg::phase_t quarter_bias(input logic [31:0] bound);
		return fog_loop_pkg::phase_t'(bound >> 2);
	endfunction

	// Wrap only in the direction the ladder is moving.
	function automatic fog_loop_pkg::step_t wrap_phase(input longint s, input logic up,
			input longint bound);
		if (up && s >= bound) begin
			return fog_loop_pkg::step_t'(s - 2 * bound);
		end
		if (!up && s <= -bound) begin
			return fog_loop_pkg::step_t'(s + 2 * bound);
		end
		return fog_loop_pkg::step_t'(s);
	endfunction

	task automatic reset_model();
		m_hcnt       = 0;
		m_trig       = 1'b0;
		m_sign       = 1'b0;
		m_dcnt       = 0;
		m_acc        = '0;
		m_err        = '0;
		m_err_valid  = 1'b0;
		m_step       = '0;
		m_step_valid = 1'b0;
		m_ladder     = '0;
		m_ramp       = '0;
		m_mod_d      = fog_loop_pkg::step_t'(quarter_bias(v2pi));
		m_bound      = fog_loop_pkg::V2PI_RESET;
	endtask

	// One clock of the loop, seen with the inputs that were present at that edge.
	task automatic step_model();
		fog_loop_pkg::phase_t mod_now;
		fog_loop_pkg::err_t   term;
		fog_loop_pkg::err_t   sum;
		fog_loop_pkg::err_t   scaled;
		longint               next_step;
		logic                 period_end;
		mod_now = m_sign ? -quarter_bias(v2pi) : quarter_bias(v2pi);
		if (!fb_on) begin
			m_ramp   = '0;
			m_ladder = '0;
		end else if (m_trig && m_step != 0) begin
			m_ramp   = wrap_phase(longint'(m_ladder) + longint'(m_mod_d), m_step > 0, m_bound);
			m_ladder = wrap_phase(longint'(m_ladder) + longint'(m_step), m_step > 0, m_bound);
		end
		m_mod_d = fog_loop_pkg::step_t'(mod_now);
		m_bound = v2pi;
		// Integrator with clamp at plus or minus v2pi.
		if (!fb_on) begin
			m_step       = '0;
			m_step_valid = 1'b0;
		end else begin
			m_step_valid = m_err_valid;
			if (m_err_valid) begin
				scaled    = m_err >>> fog_loop_pkg::GAIN_SHIFT;
				next_step = longint'(m_step) + longint'(scaled);
				if (next_step > longint'(v2pi)) begin
					next_step = longint'(v2pi);
				end else if (next_step < -longint'(v2pi)) begin
					next_step = -longint'(v2pi);
				end
				m_step = fog_loop_pkg::step_t'(next_step);
			end
		end
		period_end = 1'b0;
		if (adc_valid) begin
			term = m_sign ? -fog_loop_pkg::err_t'(adc) : fog_loop_pkg::err_t'(adc);
			sum  = m_acc + term;
			if (m_dcnt == 2 * fog_loop_pkg::HALF_PERIOD - 1) begin
				m_err      = sum;
				m_acc      = '0;
				m_dcnt     = 0;
				period_end = 1'b1;
			end else begin
				m_acc  = sum;
				m_dcnt = m_dcnt + 1;
			end
		end
		m_err_valid = period_end;
		if (m_hcnt == fog_loop_pkg::HALF_PERIOD - 1) begin
			m_hcnt = 0;
			m_trig = 1'b1;
			m_sign = ~m_sign;
		end else begin
			m_hcnt = m_hcnt + 1;
			m_trig = 1'b0;
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) begin
			n_pass++;
		end else begin
			n_fail++;
			row_fail++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_outputs();
		compare_value("o_rate_valid", 32'(rate_valid), 32'(m_step_valid));
		compare_value("o_rate", rate, m_step);
		compare_value("o_dac", 32'(dac), 32'(fog_loop_pkg::phase_t'(m_ramp)));
	endtask

	// The sample sits d above the mean in the positive half and d below it in the other.
	task automatic drive_inputs(input int r);
		logic [31:0] bits;
		int          noise;
		int          level;
		take_bits(2, bits);
		adc_valid = (bits[1:0] != 2'b00);
		take_bits(12, bits);
		noise = 0;
		if (rows[r].noise != 0) begin
			noise = int'(bits) % (2 * rows[r].noise + 1) - rows[r].noise;
		end
		level = rows[r].mean + (m_sign ? -rows[r].offset : rows[r].offset) + noise;
		adc   = fog_loop_pkg::adc_sample_t'(level);
	endtask

	initial begin : main
		int done;
		rst_n     = 1'b0;
		adc       = '0;
		adc_valid = 1'b0;
		v2pi      = rows[0].v2pi;
		fb_on     = 1'b0;
		reset_model();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < $size(rows); r++) begin
			v2pi     = rows[r].v2pi;
			fb_on    = rows[r].fb_on;
			row_fail = 0;
			done     = 0;
			while (done < rows[r].periods) begin
				drive_inputs(r);
				@(negedge clk);
				step_model();
				compare_outputs();
				if (fb_on ? rate_valid : m_err_valid) begin
					done++;
				end
			end
			if (rows[r].sat != 0) begin
				compare_value("o_rate", rate, (rows[r].sat > 0) ? v2pi : -v2pi);
			end
			$display("row %0d fb_on=%0d v2pi=%0d periods=%0d rate=%0d errors=%0d", r,
				rows[r].fb_on, rows[r].v2pi, rows[r].periods, rate, row_fail);
		end
		$display("checks passed %0d, failed %0d, property failures %0d", n_pass, n_fail,
			uut.u_props.fail_count);
		if (n_fail == 0 && uut.u_props.fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin : watchdog
		longint budget_ns;
		budget_ns = 0;
		for (int r = 0; r < $size(rows); r++) begin
			budget_ns += rows[r].periods;
		end
		// Four times the nominal run time at 4 ns per clock.
		budget_ns = budget_ns * 2 * fog_loop_pkg::HALF_PERIOD * 4 * 4;
		#(budget_ns);
		$display("timeout after %0d ns, the run did not reach its end", budget_ns);
		$display("sim failed");
		$finish;
	end

endmodule

/* fog_loop.f */
fog_loop_pkg.sv
fog_bias_mod.sv
fog_demod.sv
fog_loop_filter.sv
phase_ramp_gen.sv
fog_loop_top.sv
fog_loop_props.sv
fog_loop_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fog_loop_tb -f fog_loop.f
	./obj_dir/Vfog_loop_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
